// File: common/issue_defs.svh
//////////////////////////////////////////////////
// widths shared by the issue stage
// ROB_TAG_W sets the ROB depth to 2**ROB_TAG_W entries
// NUM_REGS must stay a power of two
//////////////////////////////////////////////////

`ifndef ISSUE_DEFS_SVH
`define ISSUE_DEFS_SVH

// data path width, RV32I only
`define XLEN 32

`define ROB_TAG_W 4 // tag wraps with the ROB tail

// architectural registers, x0 included
`define NUM_REGS 32

`endif

// File: common/issue_pkg.sv
//////////////////////////////////////////////////
// types shared by the issue stage
// op_sel codes are only unique within one fu_sel route
//////////////////////////////////////////////////

`include "issue_defs.svh"

package issue_pkg;

  typedef logic [`XLEN-1:0]             word_t;
  typedef logic [$clog2(`NUM_REGS)-1:0] reg_addr_t;
  typedef logic [`ROB_TAG_W-1:0]        rob_tag_t;
  typedef logic [1:0]                   fu_sel_t;
  typedef logic [2:0]                   op_sel_t;
  typedef logic [3:0]                   alu_op_t;

  // unit routes
  localparam fu_sel_t FU_NONE   = 2'd0;
  localparam fu_sel_t FU_ALU    = 2'd1;
  localparam fu_sel_t FU_LDST   = 2'd2;
  localparam fu_sel_t FU_BRANCH = 2'd3;

  localparam op_sel_t OP_LUI    = 3'd0; // FU_NONE
  localparam op_sel_t OP_AUIPC  = 3'd1;
  localparam op_sel_t OP_IMM    = 3'd0; // FU_ALU
  localparam op_sel_t OP_R      = 3'd1;
  localparam op_sel_t OP_LOAD   = 3'd0; // FU_LDST
  localparam op_sel_t OP_STORE  = 3'd1;
  localparam op_sel_t OP_JAL    = 3'd0; // FU_BRANCH
  localparam op_sel_t OP_JALR   = 3'd1;
  localparam op_sel_t OP_BRANCH = 3'd2;

  typedef struct packed {
    logic      en;
    fu_sel_t   fu_sel;
    op_sel_t   op_sel;
    alu_op_t   alu_op;
    reg_addr_t rd;
    reg_addr_t rs1;
    reg_addr_t rs2;
    word_t     imm;
    word_t     pc;
  } decode_t;

  typedef struct packed {
    word_t    value;
    logic     rdy;
    rob_tag_t q; // producer to wait on when not rdy
  } operand_t;

  typedef struct packed {
    logic     valid;
    rob_tag_t tag;
    word_t    value;
  } cdb_t;

  typedef struct packed {
    logic      en;
    reg_addr_t rd;
    rob_tag_t  tag;
    word_t     value;
  } commit_t;

  typedef struct packed {
    logic  valid;
    word_t value;
  } rob_read_t;

  typedef struct packed {
    logic      en;
    reg_addr_t dest;
    logic      valid; // result already known at issue
    word_t     value;
    rob_tag_t  tag;
  } rob_alloc_t;

  typedef struct packed {
    logic     alu_en;
    logic     ldst_en;
    logic     br_en;
    logic     br_comp;
    alu_op_t  alu_op;
    operand_t op1;
    operand_t op2;
    word_t    offset;
    word_t    pc;
    rob_tag_t tag;
  } dispatch_t;

  typedef struct packed {
    logic      en;
    reg_addr_t rd;
    logic      valid;
    word_t     value;
  } last_issue_t;

endpackage

// File: logic/reg_file.sv
//////////////////////////////////////////////////
// architectural registers, written only at commit
// reads don't bypass a same-cycle commit
//////////////////////////////////////////////////

`timescale 1ns/10ps

`include "issue_defs.svh"

module reg_file import issue_pkg::*;
(
  input  logic      clk,
  input  logic      rst,
  input  commit_t   commit_i,
  input  reg_addr_t rs1_i,
  input  reg_addr_t rs2_i,
  output word_t     rs1_value_o,
  output word_t     rs2_value_o
);

  word_t regs [`NUM_REGS];

  always_ff @(posedge clk)
  begin
    if (!rst)
      regs <= '{default: '0};
    else if (commit_i.en && commit_i.rd != '0) // x0 stays zero
      regs[commit_i.rd] <= commit_i.value;
  end

  assign rs1_value_o = regs[rs1_i];
  assign rs2_value_o = regs[rs2_i];

endmodule

// File: logic/prod_table.sv
//////////////////////////////////////////////////
// producer tag per register
// issue to a register beats a commit on the same edge
//////////////////////////////////////////////////

`timescale 1ns/10ps

`include "issue_defs.svh"

module prod_table import issue_pkg::*;
(
  input  logic      clk,
  input  logic      rst,
  input  logic      rename_en_i,
  input  reg_addr_t rename_rd_i,
  input  rob_tag_t  rename_tag_i,
  input  commit_t   commit_i,
  input  reg_addr_t rs1_i,
  input  reg_addr_t rs2_i,
  output logic      rs1_busy_o,
  output rob_tag_t  rs1_tag_o,
  output logic      rs2_busy_o,
  output rob_tag_t  rs2_tag_o
);

  logic [`NUM_REGS-1:0] busy;
  rob_tag_t             tags [`NUM_REGS];

  always_ff @(posedge clk)
  begin
    if (!rst)
    begin
      busy <= '0;
      tags <= '{default: '0};
    end
    else
    begin
      // only the newest producer frees the register
      if (commit_i.en && tags[commit_i.rd] == commit_i.tag)
        busy[commit_i.rd] <= 1'b0;
      if (rename_en_i)
      begin
        busy[rename_rd_i] <= 1'b1;
        tags[rename_rd_i] <= rename_tag_i;
      end
    end
  end

  assign rs1_busy_o = busy[rs1_i];
  assign rs1_tag_o  = tags[rs1_i];
  assign rs2_busy_o = busy[rs2_i];
  assign rs2_tag_o  = tags[rs2_i];

endmodule

// File: issue/operand_snoop.sv
//////////////////////////////////////////////////
// one source operand, combinational
// prod_tag_i is only meaningful while busy_i is set
//////////////////////////////////////////////////

`timescale 1ns/10ps

module operand_snoop import issue_pkg::*;
(
  input  logic        need_i,
  input  reg_addr_t   rs_i,
  input  logic        busy_i,
  input  rob_tag_t    prod_tag_i,
  input  word_t       reg_value_i,
  input  rob_read_t   rob_i,
  input  cdb_t        cdb_i,
  input  last_issue_t last_issue_i,
  input  rob_tag_t    last_tag_i,
  output operand_t    operand_o
);

  always_comb
  begin
    operand_o = '{value: '0, rdy: 1'b1, q: '0}; // unused or x0
    if (need_i && rs_i != '0)
    begin
      if (last_issue_i.en && last_issue_i.rd == rs_i)
      begin
        // alloc still in flight, ROB can't answer yet
        if (last_issue_i.valid)
          operand_o.value = last_issue_i.value;
        else
        begin
          operand_o.rdy = 1'b0;
          operand_o.q   = last_tag_i;
        end
      end
      else if (!busy_i)
        operand_o.value = reg_value_i;
      else if (rob_i.valid)
        operand_o.value = rob_i.value;
      else if (cdb_i.valid && cdb_i.tag == prod_tag_i)
        operand_o.value = cdb_i.value; // broadcast this cycle
      else
      begin
        operand_o.rdy = 1'b0;
        operand_o.q   = prod_tag_i;
      end
    end
  end

endmodule

// File: issue/issue_ctrl.sv
//////////////////////////////////////////////////
// route decode and dispatch registers, latency 1
// tag tracks the ROB tail, which lags an alloc by one
//////////////////////////////////////////////////

`timescale 1ns/10ps

module issue_ctrl import issue_pkg::*;
(
  input  logic        clk,
  input  logic        rst,
  input  logic        stall_i,
  input  decode_t     decode_i,
  input  rob_tag_t    rob_tag_i,
  input  operand_t    op1_i,
  input  operand_t    op2_i,
  output dispatch_t   dispatch_o,
  output rob_alloc_t  rob_alloc_o,
  output logic        rename_en_o,
  output reg_addr_t   rename_rd_o,
  output rob_tag_t    rename_tag_o,
  output last_issue_t last_issue_o,
  output logic        need_rs1_o,
  output logic        need_rs2_o
);

  logic        fire;
  logic        alu_sel;
  logic        ldst_sel;
  logic        br_sel;
  logic        br_comp;
  logic        alloc;
  logic        alloc_ok;
  logic        use_pc1;
  logic        use_imm2;
  logic        res_valid;
  word_t       res_value;
  word_t       offset;
  word_t       pc_four;
  word_t       pc_imm;
  rob_tag_t    next_tag;
  dispatch_t   dispatch_nxt;
  rob_alloc_t  alloc_nxt;
  last_issue_t last_nxt;

  assign pc_four  = decode_i.pc + word_t'(4);
  assign pc_imm   = decode_i.pc + decode_i.imm;
  assign next_tag = rob_tag_i + rob_tag_t'(rob_alloc_o.en);

  always_comb
  begin
    alu_sel    = 1'b0;
    ldst_sel   = 1'b0;
    br_sel     = 1'b0;
    br_comp    = 1'b0;
    alloc      = 1'b0;
    use_pc1    = 1'b0;
    use_imm2   = 1'b0;
    res_valid  = 1'b0;
    res_value  = '0;
    offset     = '0;
    need_rs1_o = 1'b0;
    need_rs2_o = 1'b0;
    case (decode_i.fu_sel)
      FU_NONE:
      begin
        alloc     = 1'b1; // result known now, no unit
        res_valid = 1'b1;
        case (decode_i.op_sel)
          OP_LUI:   res_value = decode_i.imm;
          OP_AUIPC: res_value = pc_imm;
          default:  alloc = 1'b0;
        endcase
      end
      FU_ALU:
      begin
        alu_sel    = 1'b1;
        alloc      = 1'b1;
        need_rs1_o = 1'b1;
        case (decode_i.op_sel)
          OP_IMM:  use_imm2 = 1'b1;
          OP_R:    need_rs2_o = 1'b1;
          default: alu_sel = 1'b0;
        endcase
      end
      FU_LDST:
      begin
        ldst_sel   = 1'b1;
        need_rs1_o = 1'b1;
        offset     = decode_i.imm;
        case (decode_i.op_sel)
          OP_LOAD:
          begin
            alloc    = 1'b1;
            use_imm2 = 1'b1;
          end
          OP_STORE: need_rs2_o = 1'b1; // data operand, no dest
          default:  ldst_sel = 1'b0;
        endcase
      end
      default:
      begin
        br_sel = 1'b1;
        case (decode_i.op_sel)
          OP_JAL:
          begin
            alloc     = 1'b1;
            res_valid = 1'b1;
            res_value = pc_four;
            use_pc1   = 1'b1;
            use_imm2  = 1'b1;
          end
          OP_JALR:
          begin
            alloc      = 1'b1;
            res_valid  = 1'b1;
            res_value  = pc_four;
            need_rs1_o = 1'b1;
            use_imm2   = 1'b1;
          end
          OP_BRANCH:
          begin
            br_comp    = 1'b1;
            offset     = decode_i.imm;
            need_rs1_o = 1'b1;
            need_rs2_o = 1'b1;
          end
          default: br_sel = 1'b0;
        endcase
      end
    endcase
  end

  assign fire     = decode_i.en && !stall_i;
  assign alloc_ok = fire && alloc && (decode_i.rd != '0);

  // rename lands on the issue edge
  assign rename_en_o  = alloc_ok;
  assign rename_rd_o  = decode_i.rd;
  assign rename_tag_o = next_tag;

  always_comb
  begin
    dispatch_nxt.alu_en  = fire && alu_sel;
    dispatch_nxt.ldst_en = fire && ldst_sel;
    dispatch_nxt.br_en   = fire && br_sel;
    dispatch_nxt.br_comp = br_comp;
    dispatch_nxt.alu_op  = decode_i.alu_op;
    dispatch_nxt.op1     = use_pc1 ? '{value: decode_i.pc, rdy: 1'b1, q: '0} : op1_i;
    dispatch_nxt.op2     = use_imm2 ? '{value: decode_i.imm, rdy: 1'b1, q: '0} : op2_i;
    dispatch_nxt.offset  = offset;
    dispatch_nxt.pc      = decode_i.pc;
    dispatch_nxt.tag     = next_tag;

    alloc_nxt = '{en: alloc_ok, dest: decode_i.rd, valid: res_valid,
                  value: res_value, tag: next_tag};
    last_nxt  = '{en: alloc_ok, rd: decode_i.rd, valid: res_valid, value: res_value};
  end

  always_ff @(posedge clk)
  begin
    dispatch_o   <= dispatch_nxt;
    rob_alloc_o  <= alloc_nxt;
    last_issue_o <= last_nxt;
    if (!rst)
    begin
      dispatch_o.alu_en  <= 1'b0;
      dispatch_o.ldst_en <= 1'b0;
      dispatch_o.br_en   <= 1'b0;
      rob_alloc_o.en     <= 1'b0;
      last_issue_o.en    <= 1'b0;
    end
  end

endmodule

// File: issue/issue_top.sv
//////////////////////////////////////////////////
// issue stage, ROB is external
// ROB must answer rob_rs*_tag_o in the same cycle
//////////////////////////////////////////////////

`timescale 1ns/10ps

module issue_top import issue_pkg::*;
(
  input  logic       clk,
  input  logic       rst,
  input  decode_t    decode_i,
  input  logic       stall_i,
  input  rob_tag_t   rob_tag_i,
  input  rob_read_t  rob_rs1_i,
  input  rob_read_t  rob_rs2_i,
  input  cdb_t       cdb_i,
  input  commit_t    commit_i,
  output dispatch_t  dispatch_o,
  output rob_alloc_t rob_alloc_o,
  output rob_tag_t   rob_rs1_tag_o,
  output rob_tag_t   rob_rs2_tag_o
);

  operand_t    op1;
  operand_t    op2;
  logic        rename_en;
  reg_addr_t   rename_rd;
  rob_tag_t    rename_tag;
  last_issue_t last_issue;
  logic        need_rs1;
  logic        need_rs2;
  logic        rs1_busy;
  logic        rs2_busy;
  word_t       rs1_value;
  word_t       rs2_value;

  issue_ctrl i_issue_ctrl (
    .clk          (clk),
    .rst          (rst),
    .stall_i      (stall_i),
    .decode_i     (decode_i),
    .rob_tag_i    (rob_tag_i),
    .op1_i        (op1),
    .op2_i        (op2),
    .dispatch_o   (dispatch_o),
    .rob_alloc_o  (rob_alloc_o),
    .rename_en_o  (rename_en),
    .rename_rd_o  (rename_rd),
    .rename_tag_o (rename_tag),
    .last_issue_o (last_issue),
    .need_rs1_o   (need_rs1),
    .need_rs2_o   (need_rs2)
  );

  // previous alloc tag feeds the back-to-back case
  operand_snoop i_snoop_rs1 (
    .need_i       (need_rs1),
    .rs_i         (decode_i.rs1),
    .busy_i       (rs1_busy),
    .prod_tag_i   (rob_rs1_tag_o),
    .reg_value_i  (rs1_value),
    .rob_i        (rob_rs1_i),
    .cdb_i        (cdb_i),
    .last_issue_i (last_issue),
    .last_tag_i   (rob_alloc_o.tag),
    .operand_o    (op1)
  );

  operand_snoop i_snoop_rs2 (
    .need_i       (need_rs2),
    .rs_i         (decode_i.rs2),
    .busy_i       (rs2_busy),
    .prod_tag_i   (rob_rs2_tag_o),
    .reg_value_i  (rs2_value),
    .rob_i        (rob_rs2_i),
    .cdb_i        (cdb_i),
    .last_issue_i (last_issue),
    .last_tag_i   (rob_alloc_o.tag),
    .operand_o    (op2)
  );

  prod_table i_prod_table (
    .clk          (clk),
    .rst          (rst),
    .rename_en_i  (rename_en),
    .rename_rd_i  (rename_rd),
    .rename_tag_i (rename_tag),
    .commit_i     (commit_i),
    .rs1_i        (decode_i.rs1),
    .rs2_i        (decode_i.rs2),
    .rs1_busy_o   (rs1_busy),
    .rs1_tag_o    (rob_rs1_tag_o),
    .rs2_busy_o   (rs2_busy),
    .rs2_tag_o    (rob_rs2_tag_o)
  );

  reg_file i_reg_file (
    .clk         (clk),
    .rst         (rst),
    .commit_i    (commit_i),
    .rs1_i       (decode_i.rs1),
    .rs2_i       (decode_i.rs2),
    .rs1_value_o (rs1_value),
    .rs2_value_o (rs2_value)
  );

endmodule

// File: verif/issue_assert.sv
//////////////////////////////////////////////////
// checks on the issue_ctrl outputs, bound by type
// idle while rst is low
//////////////////////////////////////////////////

`timescale 1ns/10ps

module issue_assert import issue_pkg::*;
(
  input logic       clk,
  input logic       rst,
  input logic       stall_i,
  input dispatch_t  dispatch_i,
  input rob_alloc_t alloc_i
);

  logic [2:0] unit_en;

  assign unit_en = {dispatch_i.alu_en, dispatch_i.ldst_en, dispatch_i.br_en};

  one_unit: assert property (@(posedge clk) disable iff (!rst) $onehot0(unit_en))
    else $error("more than one unit enable high: %b", unit_en);

  // stalled instruction leaves nothing behind
  quiet_after_stall: assert property (@(posedge clk) disable iff (!rst)
    $past(stall_i) |-> (unit_en == 3'b000 && !alloc_i.en))
    else $error("enable high in the cycle after a stall");

  no_x0_alloc: assert property (@(posedge clk) disable iff (!rst)
    alloc_i.en |-> alloc_i.dest != '0)
    else $error("ROB allocation with dest x0");

endmodule

bind issue_ctrl issue_assert i_issue_assert (
  .clk        (clk),
  .rst        (rst),
  .stall_i    (stall_i),
  .dispatch_i (dispatch_o),
  .alloc_i    (rob_alloc_o)
);

// File: verif/issue_tb.sv
//////////////////////////////////////////////////
// directed tests for issue_top with a small ROB model
// ROB tail advances one cycle after each allocation
// stops at the first mismatch
//////////////////////////////////////////////////

`timescale 1ns/10ps

`include "issue_defs.svh"

module issue_tb import issue_pkg::*;
();

  localparam int CLK_PERIOD   = 10;
  localparam int RESET_CYCLES = 3;
  localparam int ISSUE_COUNT  = 24;
  localparam int COMMIT_COUNT = 6;
  localparam int TEST_CYCLES  = RESET_CYCLES + 2 * ISSUE_COUNT + 2 * COMMIT_COUNT + 10;
  localparam int ROB_DEPTH    = 2 ** `ROB_TAG_W;

  logic       clk;
  logic       rst;
  logic       stall;
  decode_t    decode;
  rob_read_t  rob_rs1;
  rob_read_t  rob_rs2;
  cdb_t       cdb;
  commit_t    commit;
  dispatch_t  dispatch;
  rob_alloc_t rob_alloc;
  rob_tag_t   rob_rs1_tag;
  rob_tag_t   rob_rs2_tag;

  // ROB model
  rob_tag_t   tail = '0;
  logic       rob_valid [ROB_DEPTH] = '{default: 1'b0};
  word_t      rob_value [ROB_DEPTH] = '{default: '0};
  logic       done_en;    // one written-back entry
  rob_tag_t   done_tag;
  word_t      done_value;

  int         seed = 32'h2208addb;
  rob_tag_t   exp_tag;
  word_t      r1_val;
  word_t      r2_val;

  issue_top i_issue_top (
    .clk           (clk),
    .rst           (rst),
    .decode_i      (decode),
    .stall_i       (stall),
    .rob_tag_i     (tail),
    .rob_rs1_i     (rob_rs1),
    .rob_rs2_i     (rob_rs2),
    .cdb_i         (cdb),
    .commit_i      (commit),
    .dispatch_o    (dispatch),
    .rob_alloc_o   (rob_alloc),
    .rob_rs1_tag_o (rob_rs1_tag),
    .rob_rs2_tag_o (rob_rs2_tag)
  );

  initial
  begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  always @(posedge clk)
  begin
    if (!rst)
      tail <= '0;
    else if (rob_alloc.en)
    begin
      tail <= tail + rob_tag_t'(1);
      rob_valid[rob_alloc.tag] <= rob_alloc.valid;
      rob_value[rob_alloc.tag] <= rob_alloc.value;
    end
  end

  always_comb
  begin
    rob_rs1 = '{valid: rob_valid[rob_rs1_tag], value: rob_value[rob_rs1_tag]};
    rob_rs2 = '{valid: rob_valid[rob_rs2_tag], value: rob_value[rob_rs2_tag]};
    if (done_en && done_tag == rob_rs1_tag)
      rob_rs1 = '{valid: 1'b1, value: done_value};
    if (done_en && done_tag == rob_rs2_tag)
      rob_rs2 = '{valid: 1'b1, value: done_value};
  end

  initial
  begin
    #(4 * TEST_CYCLES * CLK_PERIOD);
    $display("watchdog expired, tests did not finish within %0d cycles", 4 * TEST_CYCLES);
    abort_run();
  end

  task abort_run;
    $display("TB FAILED");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_word(input string name, input word_t act, input word_t exp);
    if (act !== exp)
    begin
      $display("ERR %s: got %h expected %h", name, act, exp);
      abort_run();
    end
  endtask

  task automatic check_operand(input string name, input operand_t act, input operand_t exp);
    logic bad;
    bad = (act.rdy !== exp.rdy);
    if (exp.rdy)
      bad = bad || act.value !== exp.value;
    else
      bad = bad || act.q !== exp.q;
    if (bad)
    begin
      $display("ERR %s: got value %h rdy %h q %h", name, act.value, act.rdy, act.q);
      $display("    expected value %h rdy %h q %h", exp.value, exp.rdy, exp.q);
      abort_run();
    end
  endtask

  task automatic check_alloc(input string name, input rob_alloc_t act, input rob_alloc_t exp);
    logic bad;
    bad = (act.en !== exp.en);
    if (exp.en)
      bad = bad || act.dest !== exp.dest || act.valid !== exp.valid || act.tag !== exp.tag
            || (exp.valid && act.value !== exp.value);
    if (bad)
    begin
      $display("ERR %s rob_alloc_o: got en %h dest %h valid %h value %h tag %h",
               name, act.en, act.dest, act.valid, act.value, act.tag);
      $display("    expected en %h dest %h valid %h value %h tag %h",
               exp.en, exp.dest, exp.valid, exp.value, exp.tag);
      abort_run();
    end
  endtask

  task automatic check_units(input string name, input logic alu, input logic ldst,
                             input logic br);
    check_word({name, " dispatch_o.alu_en"}, word_t'(dispatch.alu_en), word_t'(alu));
    check_word({name, " dispatch_o.ldst_en"}, word_t'(dispatch.ldst_en), word_t'(ldst));
    check_word({name, " dispatch_o.br_en"}, word_t'(dispatch.br_en), word_t'(br));
  endtask

  // allocations come in order and tags count up from 0
  task automatic expect_alloc(input string name, input reg_addr_t dst, input logic valid,
                              input word_t value);
    rob_alloc_t exp;
    exp = '{en: 1'b1, dest: dst, valid: valid, value: value, tag: exp_tag};
    check_alloc(name, rob_alloc, exp);
    check_word({name, " dispatch_o.tag"}, word_t'(dispatch.tag), word_t'(exp_tag));
    exp_tag = exp_tag + rob_tag_t'(1);
  endtask

  function automatic operand_t ready_op(input word_t value);
    return '{value: value, rdy: 1'b1, q: '0};
  endfunction

  function automatic operand_t wait_op(input rob_tag_t tag);
    return '{value: '0, rdy: 1'b0, q: tag};
  endfunction

  function automatic decode_t make_dec(input fu_sel_t fu, input op_sel_t op,
                                       input reg_addr_t dst, input reg_addr_t src1,
                                       input reg_addr_t src2, input word_t imm,
                                       input word_t pc);
    return '{en: 1'b1, fu_sel: fu, op_sel: op, alu_op: 4'h5, rd: dst, rs1: src1,
             rs2: src2, imm: imm, pc: pc};
  endfunction

  task automatic drive_decode(input decode_t d);
    @(posedge clk);
    decode <= d;
  endtask

  // results are registered on the edge after d is sampled
  task automatic issue_one(input decode_t d);
    drive_decode(d);
    drive_decode('0);
    @(negedge clk);
  endtask

  task automatic commit_reg(input reg_addr_t idx, input rob_tag_t ptag, input word_t data);
    @(posedge clk);
    commit <= '{en: 1'b1, rd: idx, tag: ptag, value: data};
    @(posedge clk);
    commit <= '0;
  endtask

  task automatic test_result_ops;
    word_t imm;
    word_t pc;
    imm = $random(seed);
    pc  = $random(seed);
    pc[1:0] = 2'b00;
    issue_one(make_dec(FU_NONE, OP_LUI, 5'd10, '0, '0, imm, pc));
    expect_alloc("lui", 5'd10, 1'b1, imm);
    check_units("lui", 1'b0, 1'b0, 1'b0);
    issue_one(make_dec(FU_NONE, OP_AUIPC, 5'd11, '0, '0, imm, pc));
    expect_alloc("auipc", 5'd11, 1'b1, pc + imm);
    issue_one(make_dec(FU_BRANCH, OP_JAL, 5'd12, '0, '0, imm, pc));
    expect_alloc("jal", 5'd12, 1'b1, pc + 32'd4);
    check_units("jal", 1'b0, 1'b0, 1'b1);
    check_word("jal dispatch_o.pc", dispatch.pc, pc);
    check_operand("jal dispatch_o.op1", dispatch.op1, ready_op(pc));
    check_operand("jal dispatch_o.op2", dispatch.op2, ready_op(imm));
    issue_one(make_dec(FU_BRANCH, OP_JALR, 5'd13, '0, '0, imm, pc));
    expect_alloc("jalr", 5'd13, 1'b1, pc + 32'd4);
    check_operand("jalr dispatch_o.op2", dispatch.op2, ready_op(imm));
  endtask

  task automatic test_regfile_read;
    word_t imm;
    r1_val = $random(seed);
    r2_val = $random(seed);
    imm    = $random(seed);
    commit_reg(5'd1, '0, r1_val);
    commit_reg(5'd2, '0, r2_val);
    issue_one(make_dec(FU_ALU, OP_R, 5'd3, 5'd1, 5'd2, '0, '0));
    check_units("r-type", 1'b1, 1'b0, 1'b0);
    check_word("r-type dispatch_o.alu_op", word_t'(dispatch.alu_op), 32'h5);
    check_operand("r-type dispatch_o.op1", dispatch.op1, ready_op(r1_val));
    check_operand("r-type dispatch_o.op2", dispatch.op2, ready_op(r2_val));
    expect_alloc("r-type", 5'd3, 1'b0, '0);
    issue_one(make_dec(FU_ALU, OP_IMM, 5'd4, '0, '0, imm, '0));
    check_operand("x0 dispatch_o.op1", dispatch.op1, ready_op('0));
    check_operand("imm dispatch_o.op2", dispatch.op2, ready_op(imm));
    expect_alloc("op-imm", 5'd4, 1'b0, '0);
    issue_one(make_dec(FU_ALU, OP_IMM, 5'd0, 5'd1, '0, imm, '0)); // dest x0
    check_units("op-imm to x0", 1'b1, 1'b0, 1'b0);
    check_alloc("op-imm to x0", rob_alloc, '0);
  endtask

  task automatic test_rob_wait;
    rob_tag_t prod_tag;
    word_t    v;
    word_t    w;
    v = $random(seed);
    w = $random(seed);
    prod_tag = exp_tag;
    issue_one(make_dec(FU_ALU, OP_IMM, 5'd6, 5'd1, '0, 32'h10, '0));
    expect_alloc("producer", 5'd6, 1'b0, '0);
    drive_decode(make_dec(FU_ALU, OP_R, 5'd7, 5'd6, 5'd6, '0, '0));
    @(negedge clk);
    check_word("rob_rs1_tag_o", word_t'(rob_rs1_tag), word_t'(prod_tag));
    check_word("rob_rs2_tag_o", word_t'(rob_rs2_tag), word_t'(prod_tag));
    drive_decode('0);
    @(negedge clk);
    check_operand("rob wait dispatch_o.op1", dispatch.op1, wait_op(prod_tag));
    check_operand("rob wait dispatch_o.op2", dispatch.op2, wait_op(prod_tag));
    expect_alloc("rob wait", 5'd7, 1'b0, '0);
    @(posedge clk);
    done_en    <= 1'b1;
    done_tag   <= prod_tag;
    done_value <= v;
    issue_one(make_dec(FU_ALU, OP_R, 5'd7, 5'd6, 5'd6, '0, '0));
    check_operand("rob hit dispatch_o.op1", dispatch.op1, ready_op(v));
    check_operand("rob hit dispatch_o.op2", dispatch.op2, ready_op(v));
    expect_alloc("rob hit", 5'd7, 1'b0, '0);
    @(posedge clk);
    done_en <= 1'b0;
    cdb     <= '{valid: 1'b1, tag: prod_tag, value: w};
    issue_one(make_dec(FU_ALU, OP_R, 5'd7, 5'd6, 5'd6, '0, '0));
    check_operand("cdb hit dispatch_o.op1", dispatch.op1, ready_op(w));
    check_operand("cdb hit dispatch_o.op2", dispatch.op2, ready_op(w));
    expect_alloc("cdb hit", 5'd7, 1'b0, '0);
    @(posedge clk);
    cdb <= '0;
  endtask

  task automatic test_back_to_back;
    rob_tag_t prod_tag;
    word_t    v;
    v = $random(seed);
    drive_decode(make_dec(FU_NONE, OP_LUI, 5'd8, '0, '0, v, '0));
    drive_decode(make_dec(FU_ALU, OP_IMM, 5'd9, 5'd8, '0, 32'h4, '0));
    @(negedge clk);
    expect_alloc("b2b lui", 5'd8, 1'b1, v);
    drive_decode('0);
    @(negedge clk);
    check_operand("b2b lui dispatch_o.op1", dispatch.op1, ready_op(v));
    expect_alloc("b2b lui consumer", 5'd9, 1'b0, '0);
    prod_tag = exp_tag;
    drive_decode(make_dec(FU_ALU, OP_IMM, 5'd14, 5'd1, '0, 32'h8, '0));
    drive_decode(make_dec(FU_ALU, OP_IMM, 5'd15, 5'd14, '0, 32'h2, '0));
    @(negedge clk);
    expect_alloc("b2b alu", 5'd14, 1'b0, '0);
    drive_decode('0);
    @(negedge clk);
    check_operand("b2b alu dispatch_o.op1", dispatch.op1, wait_op(prod_tag));
    expect_alloc("b2b alu consumer", 5'd15, 1'b0, '0); // tail not yet moved
  endtask

  task automatic test_stall;
    word_t vs;
    vs = $random(seed);
    commit_reg(5'd16, '0, vs);
    @(posedge clk);
    stall  <= 1'b1;
    decode <= make_dec(FU_ALU, OP_IMM, 5'd16, 5'd1, '0, 32'h3, '0);
    repeat (3)
    begin
      @(negedge clk);
      check_units("stalled", 1'b0, 1'b0, 1'b0);
      check_alloc("stalled", rob_alloc, '0);
    end
    @(posedge clk);
    stall  <= 1'b0;
    decode <= '0;
    @(negedge clk);
    check_units("after stall", 1'b0, 1'b0, 1'b0);
    check_alloc("after stall", rob_alloc, '0);
    issue_one(make_dec(FU_ALU, OP_IMM, 5'd17, 5'd16, '0, 32'h1, '0));
    check_operand("after stall dispatch_o.op1", dispatch.op1, ready_op(vs));
    expect_alloc("after stall", 5'd17, 1'b0, '0);
  endtask

  task automatic test_commit_branch;
    rob_tag_t prod_tag;
    word_t    vc;
    word_t    imm;
    vc  = $random(seed);
    imm = $random(seed);
    prod_tag = exp_tag;
    issue_one(make_dec(FU_ALU, OP_IMM, 5'd18, 5'd1, '0, 32'h7, '0));
    expect_alloc("commit producer", 5'd18, 1'b0, '0);
    commit_reg(5'd18, prod_tag, vc);
    issue_one(make_dec(FU_ALU, OP_IMM, 5'd19, 5'd18, '0, 32'h1, '0));
    check_operand("committed dispatch_o.op1", dispatch.op1, ready_op(vc));
    expect_alloc("committed consumer", 5'd19, 1'b0, '0);
    issue_one(make_dec(FU_BRANCH, OP_BRANCH, 5'd20, 5'd1, 5'd2, imm, 32'h100));
    check_units("branch", 1'b0, 1'b0, 1'b1);
    check_word("branch dispatch_o.br_comp", word_t'(dispatch.br_comp), 32'h1);
    check_word("branch dispatch_o.offset", dispatch.offset, imm);
    check_operand("branch dispatch_o.op1", dispatch.op1, ready_op(r1_val));
    check_operand("branch dispatch_o.op2", dispatch.op2, ready_op(r2_val));
    check_alloc("branch", rob_alloc, '0);
  endtask

  initial
  begin
    rst        = 1'b0;
    stall      = 1'b0;
    decode     = '0;
    cdb        = '0;
    commit     = '0;
    done_en    = 1'b0;
    done_tag   = '0;
    done_value = '0;
    exp_tag    = '0;
    repeat (RESET_CYCLES) @(posedge clk);
    rst <= 1'b1;
    test_result_ops();
    test_regfile_read();
    test_rob_wait();
    test_back_to_back();
    test_stall();
    test_commit_branch();
    repeat (2) @(posedge clk);
    $display("TB PASSED");
    $finish;
  end

endmodule

// File: files.f
+incdir+common
common/issue_pkg.sv
logic/reg_file.sv
logic/prod_table.sv
issue/operand_snoop.sv
issue/issue_ctrl.sv
issue/issue_top.sv
verif/issue_assert.sv
verif/issue_tb.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
TOP       := issue_tb
FILELIST  := files.f
OBJ_DIR   := obj_dir
LOG       := sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "TB FAILED" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "TB PASSED" $(LOG) || (echo "simulation ended without a pass line"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
